//--- logic/accumulate_result.sv
`timescale 1ns/10ps

module accumulate_result #(
	parameter int acc_width = mac_pkg::DEFAULT_ACC_WIDTH
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 m_valid,
	input  mac_pkg::product_t    m_product,
	input  logic                 m_half,
	input  logic                 m_clear,
	input  logic                 m_signed,
	output logic                 out_valid,
	output logic [acc_width-1:0] acc
);

	import mac_pkg::*;

	localparam int half_width = acc_width / 2;

	lane_product_t        lo_product;
	lane_product_t        hi_product;
	logic [acc_width-1:0] full_ext;
	logic [half_width-1:0] lo_ext;
	logic [half_width-1:0] hi_ext;
	logic [acc_width-1:0] acc_base;
	logic [acc_width-1:0] full_sum;
	logic [half_width-1:0] lo_sum;
	logic [half_width-1:0] hi_sum;
	logic [acc_width-1:0] acc_next;

	// lane fields of the packed half mode product.
	assign lo_product = m_product[7:0];
	assign hi_product = m_product[17:10];

	// sign or zero extension, chosen once per item in decode.
	assign full_ext = m_signed ? acc_width'(signed'(m_product)) : acc_width'(m_product);
	assign lo_ext   = m_signed ? half_width'(signed'(lo_product)) : half_width'(lo_product);
	assign hi_ext   = m_signed ? half_width'(signed'(hi_product)) : half_width'(hi_product);

	// a clear starts from zero, so the product is loaded instead of added.
	assign acc_base = m_clear ? '0 : acc;

	assign full_sum = acc_base + full_ext;
	assign lo_sum   = acc_base[half_width-1:0] + lo_ext;	// carry out is dropped.
	assign hi_sum   = acc_base[acc_width-1:half_width] + hi_ext;

	// half mode keeps the two lanes apart.
	assign acc_next = m_half ? {hi_sum, lo_sum} : full_sum;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			acc       <= '0;
		end else begin
			out_valid <= m_valid;	// one pulse per item.
			if (m_valid) begin
				acc <= acc_next;
			end
		end
	end

endmodule

//--- logic/mac_pkg.sv
package mac_pkg;

	// operand and product geometry of the 9 by 9 multiplier.
	localparam int OPERAND_WIDTH = 9;
	localparam int EXT_WIDTH = OPERAND_WIDTH + 1;	// one extra bit for the sign extension.
	localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;
	localparam int LANE_PRODUCT_WIDTH = 8;

	// accumulator width used when the top level is not told otherwise.
	localparam int DEFAULT_ACC_WIDTH = 32;

	// half mode: low lane in bits 3..0, high lane in bits 8..5, bit 4 unused.
	typedef logic [OPERAND_WIDTH-1:0] operand_t;

	// operand after sign extension, with bits 9 and 4 depending on the mode.
	typedef logic [EXT_WIDTH-1:0] ext_operand_t;

	// half mode: low lane in 7..0, high lane in 17..10, bits 9..8 forced to zero.
	typedef logic [PRODUCT_WIDTH-1:0] product_t;

	// running sum of the partial product rows, one bit wider than the product.
	typedef logic [PRODUCT_WIDTH:0] pp_sum_t;

	typedef logic [LANE_PRODUCT_WIDTH-1:0] lane_product_t;

endpackage

//--- logic/multiply_stage.sv
`timescale 1ns/10ps

module multiply_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              d_valid,
	input  mac_pkg::operand_t d_a,
	input  mac_pkg::operand_t d_b,
	input  logic              d_a_sign,
	input  logic              d_b_sign,
	input  logic              d_half,
	input  logic              d_clear,
	input  logic              d_signed,
	output logic              m_valid,
	output mac_pkg::product_t m_product,
	output logic              m_half,
	output logic              m_clear,
	output logic              m_signed
);

	import mac_pkg::*;

	product_t product;	// combinational multiplier result.

	scalable_multiplier mult_i (
		.a       (d_a),
		.b       (d_b),
		.a_sign  (d_a_sign),
		.b_sign  (d_b_sign),
		.half    (d_half),
		.product (product)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_valid <= 1'b0;
		end else begin
			m_valid <= d_valid;
		end
	end

	// the partial product adder gets this whole cycle to settle.
	always_ff @(posedge clk) begin
		if (d_valid) begin
			m_product <= product;
			m_half    <= d_half;
			m_clear   <= d_clear;
			m_signed  <= d_signed;	// extension rule for the accumulator.
		end
	end

endmodule

//--- logic/operand_decode.sv
`timescale 1ns/10ps

module operand_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  mac_pkg::operand_t a,
	input  mac_pkg::operand_t b,
	input  logic              a_sign,
	input  logic              b_sign,
	input  logic              half,
	input  logic              clear,
	output logic              d_valid,
	output mac_pkg::operand_t d_a,
	output mac_pkg::operand_t d_b,
	output logic              d_a_sign,
	output logic              d_b_sign,
	output logic              d_half,
	output logic              d_clear,
	output logic              d_signed
);

	// valid marker for the decode register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= in_valid;	// one cycle behind the strobe.
		end
	end

	// operand and control capture, held while no item arrives.
	always_ff @(posedge clk) begin
		if (in_valid) begin
			d_a      <= a;
			d_b      <= b;
			d_a_sign <= a_sign;
			d_b_sign <= b_sign;
			d_half   <= half;
			d_clear  <= clear;
			// a product is signed as soon as one of its factors is.
			d_signed <= a_sign | b_sign;
		end
	end

endmodule

//--- logic/scalable_mac.sv
`timescale 1ns/10ps

module scalable_mac #(
	parameter int acc_width = mac_pkg::DEFAULT_ACC_WIDTH
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  mac_pkg::operand_t    a,
	input  mac_pkg::operand_t    b,
	input  logic                 a_sign,
	input  logic                 b_sign,
	input  logic                 half,
	input  logic                 clear,
	output logic                 out_valid,
	output logic [acc_width-1:0] acc
);

	import mac_pkg::*;

	// decode to execute.
	logic     d_valid;
	operand_t d_a;
	operand_t d_b;
	logic     d_a_sign;
	logic     d_b_sign;
	logic     d_half;
	logic     d_clear;
	logic     d_signed;

	// execute to result.
	logic     m_valid;
	product_t m_product;
	logic     m_half;
	logic     m_clear;
	logic     m_signed;

	operand_decode decode_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.a_sign   (a_sign),
		.b_sign   (b_sign),
		.half     (half),
		.clear    (clear),
		.d_valid  (d_valid),
		.d_a      (d_a),
		.d_b      (d_b),
		.d_a_sign (d_a_sign),
		.d_b_sign (d_b_sign),
		.d_half   (d_half),
		.d_clear  (d_clear),
		.d_signed (d_signed)
	);

	multiply_stage execute_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.d_valid   (d_valid),
		.d_a       (d_a),
		.d_b       (d_b),
		.d_a_sign  (d_a_sign),
		.d_b_sign  (d_b_sign),
		.d_half    (d_half),
		.d_clear   (d_clear),
		.d_signed  (d_signed),
		.m_valid   (m_valid),
		.m_product (m_product),
		.m_half    (m_half),
		.m_clear   (m_clear),
		.m_signed  (m_signed)
	);

	accumulate_result #(
		.acc_width (acc_width)
	) result_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.m_valid   (m_valid),
		.m_product (m_product),
		.m_half    (m_half),
		.m_clear   (m_clear),
		.m_signed  (m_signed),
		.out_valid (out_valid),
		.acc       (acc)
	);

endmodule

//--- logic/scalable_multiplier.sv
`timescale 1ns/10ps

module scalable_multiplier (
	input  mac_pkg::operand_t a,
	input  mac_pkg::operand_t b,
	input  logic              a_sign,
	input  logic              b_sign,
	input  logic              half,
	output mac_pkg::product_t product
);

	import mac_pkg::*;

	ext_operand_t a_ext;
	ext_operand_t b_ext;
	pp_sum_t      lo_rows;	// rows 0..4, the low lane in half mode.
	pp_sum_t      hi_rows;	// rows 5..9, the high lane in half mode.
	pp_sum_t      full_sum;

	// bit 9 holds the sign of the full operand or of the high lane.
	// in half mode bit 4 holds the low lane sign instead of the operand bit.
	assign a_ext = {a_sign & a[8], a[8:5], (half ? (a_sign & a[3]) : a[4]), a[3:0]};
	assign b_ext = {b_sign & b[8], b[8:5], (half ? (b_sign & b[3]) : b[4]), b[3:0]};

	// modified Baugh-Wooley matrix, one row per bit of a_ext.
	always_comb begin
		pp_sum_t row;
		logic    pp_bit;
		int      sign_pos;
		lo_rows = '0;
		hi_rows = '0;
		for (int i = 0; i < EXT_WIDTH; i++) begin
			sign_pos = (half && i < 5) ? 4 : 9;	// sign row and column of this block.
			row = '0;
			for (int j = 0; j < EXT_WIDTH; j++) begin
				pp_bit = a_ext[i] & b_ext[j];
				if ((i == sign_pos) != (j == sign_pos)) begin
					pp_bit = ~pp_bit;
				end
				if (half && ((i < 5) != (j < 5))) begin
					pp_bit = 1'b0;	// no cross-lane terms.
				end
				row[i + j] = pp_bit;
			end
			if (i < 5) begin
				lo_rows = lo_rows + row;
			end else begin
				hi_rows = hi_rows + row;
			end
		end
		// correction bits; the top one at 2^19 lies above the sum.
		if (half) begin
			lo_rows = lo_rows + pp_sum_t'((1 << 5) | (1 << 9));
			hi_rows = hi_rows + pp_sum_t'(1 << 15);
		end else begin
			lo_rows = lo_rows + pp_sum_t'(1 << 10);
		end
	end

	assign full_sum = lo_rows + hi_rows;

	// half mode drops the low lane carry and zeroes bits 9..8.
	assign product = half ? {hi_rows[17:10], 2'b00, lo_rows[7:0]} : full_sum[17:0];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the scalable MAC testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
	echo "cannot create $build_dir"
	exit 1
fi

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module scalable_mac_tb \
	-Mdir "$build_dir/obj_dir" \
	-o scalable_mac_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$build_dir/obj_dir/scalable_mac_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
fi

if grep -q "^Simulation finished: PASS$" "$log_file" && [ $sim_status -eq 0 ]; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

//--- tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
	parameter int period = 40	// in ns.
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;
		end
	end

endmodule

//--- tests/scalable_mac_assertions.sv
`timescale 1ns/10ps

module scalable_mac_assertions #(
	parameter int acc_width = mac_pkg::DEFAULT_ACC_WIDTH
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 in_valid,
	input logic                 out_valid,
	input logic [acc_width-1:0] acc
);

	// decode, execute and result registers give three cycles of latency.
	property latency_three;
		@(posedge clk) disable iff (!rst_n)
			out_valid == $past(in_valid, 3);
	endproperty

	property quiet_in_reset;
		@(posedge clk) !rst_n |-> !out_valid;
	endproperty

	property acc_known;
		@(posedge clk) disable iff (!rst_n)
			out_valid |-> !$isunknown(acc);
	endproperty

	latency_check: assert property (latency_three)
		else $error("out_valid does not follow in_valid by three cycles");

	reset_check: assert property (quiet_in_reset)
		else $error("out_valid is high while reset is active");

	known_check: assert property (acc_known)
		else $error("acc has unknown bits while out_valid is high");

endmodule

//--- tests/scalable_mac_tb.sv
`timescale 1ns/10ps

module scalable_mac_tb;

	import mac_pkg::*;

	localparam int acc_width = 32;
	localparam int half_width = acc_width / 2;

	typedef struct {
		operand_t a;
		operand_t b;
		logic     a_sign;
		logic     b_sign;
		logic     half;
		logic     clear;
		int       gap;	// idle cycles after the item.
	} item_t;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	operand_t             a;
	operand_t             b;
	logic                 a_sign;
	logic                 b_sign;
	logic                 half;
	logic                 clear;
	logic                 out_valid;
	logic [acc_width-1:0] acc;

	item_t                items[$];
	logic [acc_width-1:0] expected_q[$];
	int                   strobe_q[$];
	logic [acc_width-1:0] model_acc = '0;
	int                   total_cycles = 0;
	int                   cycle_limit = 0;
	int                   cycle_count = 0;
	int                   neg_count = 0;
	int                   results_seen = 0;

	clock_gen #(
		.period (40)
	) clock_i (
		.clk (clk)
	);

	scalable_mac #(
		.acc_width (acc_width)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.a_sign    (a_sign),
		.b_sign    (b_sign),
		.half      (half),
		.clear     (clear),
		.out_valid (out_valid),
		.acc       (acc)
	);

	bind scalable_mac scalable_mac_assertions #(
		.acc_width (acc_width)
	) assertions_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.acc       (acc)
	);

	task automatic stop_on_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare_value(string name, logic [63:0] actual, logic [63:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			stop_on_failure();
		end
	endtask

	// field of an operand as a plain integer.
	function automatic int lane_value(operand_t v, int lsb, int width, logic is_signed);
		int raw;
		raw = int'(v >> lsb) & ((1 << width) - 1);
		if (is_signed && raw >= (1 << (width - 1))) begin
			raw = raw - (1 << width);
		end
		return raw;
	endfunction

	// accumulator after one item; the two halves wrap on their own in half mode.
	function automatic logic [acc_width-1:0] next_acc(logic [acc_width-1:0] acc_now,
			operand_t op_a, operand_t op_b, logic a_s, logic b_s, logic is_half,
			logic is_clear);
		logic [acc_width-1:0]  base;
		logic [half_width-1:0] lo;
		logic [half_width-1:0] hi;
		int                    prod;
		base = is_clear ? '0 : acc_now;
		if (!is_half) begin
			prod = lane_value(op_a, 0, 9, a_s) * lane_value(op_b, 0, 9, b_s);
			return base + acc_width'(prod);
		end
		prod = lane_value(op_a, 0, 4, a_s) * lane_value(op_b, 0, 4, b_s);
		lo = base[half_width-1:0] + half_width'(prod);
		prod = lane_value(op_a, 5, 4, a_s) * lane_value(op_b, 5, 4, b_s);
		hi = base[acc_width-1:half_width] + half_width'(prod);
		return {hi, lo};
	endfunction

	// mostly back to back, now and then a short pause.
	function automatic int pick_gap();
		if ($urandom_range(2, 0) == 0) begin
			return int'($urandom_range(4, 1));
		end else begin
			return 0;
		end
	endfunction

	task automatic add_item(operand_t op_a, operand_t op_b, logic a_s, logic b_s,
			logic is_half, logic is_clear);
		item_t it;
		it.a      = op_a;
		it.b      = op_b;
		it.a_sign = a_s;
		it.b_sign = b_s;
		it.half   = is_half;
		it.clear  = is_clear;
		it.gap    = pick_gap();
		items.push_back(it);
		total_cycles += 1 + it.gap;
	endtask

	task automatic build_stimulus();
		int run_len;
		logic run_half;
		// single full mode products under all four sign combinations.
		for (int i = 0; i < 40; i++) begin
			add_item(operand_t'($urandom), operand_t'($urandom), 1'(i), 1'(i >> 1), 1'b0, 1'b1);
		end
		// single half mode products, bit 4 random and ignored.
		for (int i = 0; i < 40; i++) begin
			add_item(operand_t'($urandom), operand_t'($urandom), 1'(i), 1'(i >> 1), 1'b1, 1'b1);
		end
		// accumulation runs in one mode.
		for (int r = 0; r < 12; r++) begin
			run_len = $urandom_range(20, 1);
			run_half = 1'($urandom);
			for (int i = 0; i < run_len; i++) begin
				add_item(operand_t'($urandom), operand_t'($urandom), 1'($urandom),
					1'($urandom), run_half, i == 0);
			end
		end
		// low half near the top, so the half mode adds wrap it.
		add_item(9'h1ff, 9'h1ff, 1'b0, 1'b0, 1'b0, 1'b1);
		for (int i = 0; i < 10; i++) begin
			add_item(9'h1ef | operand_t'(($urandom & 1) << 4), 9'h1ef, 1'b0, 1'b0, 1'b1, 1'b0);
		end
		// runs that switch mode without a clear.
		for (int r = 0; r < 8; r++) begin
			run_len = $urandom_range(20, 4);
			for (int i = 0; i < run_len; i++) begin
				add_item(operand_t'($urandom), operand_t'($urandom), 1'($urandom),
					1'($urandom), 1'($urandom), i == 0);
			end
		end
	endtask

	task automatic drive_item(item_t it);
		in_valid <= 1'b1;
		a        <= it.a;
		b        <= it.b;
		a_sign   <= it.a_sign;
		b_sign   <= it.b_sign;
		half     <= it.half;
		clear    <= it.clear;
		@(posedge clk);
		in_valid <= 1'b0;
		for (int g = 0; g < it.gap; g++) begin
			a     <= operand_t'($urandom);	// noise between items.
			b     <= operand_t'($urandom);
			clear <= 1'($urandom);
			@(posedge clk);
		end
	endtask

	initial begin
		rst_n    <= 1'b0;
		in_valid <= 1'b0;
		a        <= '0;
		b        <= '0;
		a_sign   <= 1'b0;
		b_sign   <= 1'b0;
		half     <= 1'b0;
		clear    <= 1'b0;
		void'($urandom(98440));
		build_stimulus();
		cycle_limit = 4 * total_cycles + 100;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (int i = 0; i < items.size(); i++) begin
			drive_item(items[i]);
		end
		while (expected_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (5) @(posedge clk);	// catch any stray out_valid.
		$display("Simulation finished: PASS");
		$finish;
	end

	// model and output check, both sampled mid cycle.
	always @(negedge clk) begin
		logic [acc_width-1:0] exp_acc;
		int strobe_cycle;
		neg_count++;
		if (rst_n && in_valid) begin
			model_acc = next_acc(model_acc, a, b, a_sign, b_sign, half, clear);
			expected_q.push_back(model_acc);
			strobe_q.push_back(neg_count);
		end
		if (out_valid) begin
			if (expected_q.size() == 0) begin
				$display("out_valid pulsed at time %0t with no item outstanding", $time);
				stop_on_failure();
			end else begin
				exp_acc = expected_q.pop_front();
				strobe_cycle = strobe_q.pop_front();
				results_seen++;
				compare_value("out_valid latency", 64'(neg_count - strobe_cycle), 64'd3);
				compare_value("acc", 64'(acc), 64'(exp_acc));
			end
		end else if (results_seen == 0) begin
			compare_value("acc", 64'(acc), 64'd0);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles with results still missing", cycle_count);
			stop_on_failure();
		end
	end

endmodule

//--- vlog.f
logic/mac_pkg.sv
logic/operand_decode.sv
logic/scalable_multiplier.sv
logic/multiply_stage.sv
logic/accumulate_result.sv
logic/scalable_mac.sv
tests/clock_gen.sv
tests/scalable_mac_assertions.sv
tests/scalable_mac_tb.sv
